// File: rtl/cache_defines.svh
/*
 * Blocking cache sizes: address, word and line widths, set count
 */

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Processor side
`define CACHE_ADDR_W   32
`define CACHE_WORD_W   32
`define CACHE_OPQ_W    8

// Line geometry, 16 bytes per line
`define CACHE_LINE_W   128
`define CACHE_OFF_W    4

// Two ways of 8 sets, 256 bytes in all
`define CACHE_NUM_SETS 8
`define CACHE_IDX_W    3

`endif

// File: rtl/cache_pkg.sv
/*
 * Blocking cache types: widths, operations, messages and the
 * control and status bundles between control unit and datapath
 */

`include "cache_defines.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0]              addr_t;
  typedef logic [`CACHE_WORD_W-1:0]              word_t;
  typedef logic [`CACHE_LINE_W-1:0]              line_t;
  // Full line address, the address without its offset
  typedef logic [`CACHE_ADDR_W-`CACHE_OFF_W-1:0] tag_t;
  typedef logic [`CACHE_IDX_W-1:0]               idx_t;
  typedef logic [`CACHE_OPQ_W-1:0]               opq_t;

  typedef enum logic [2:0] {
    OP_READ    = 3'd0,
    OP_WRITE   = 3'd1,
    OP_AMO_ADD = 3'd2,
    OP_AMO_AND = 3'd3,
    OP_AMO_OR  = 3'd4
  } mem_op_e;

  // ==========================================================================
  // Messages
  // ==========================================================================

  typedef struct packed {
    mem_op_e op;
    opq_t    opaque;
    addr_t   addr;
    word_t   data;
  } cache_req_t;

  typedef struct packed {
    mem_op_e op;
    opq_t    opaque;
    word_t   data;
  } cache_resp_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    line_t data;
  } mem_req_t;

  // ==========================================================================
  // Control unit and datapath
  // ==========================================================================

  typedef struct packed {
    logic                      req_en;
    logic                      memresp_en;
    logic                      is_refill;
    logic [1:0]                tag_wen;
    logic                      way_sel;
    logic                      data_wen;
    logic [`CACHE_LINE_W/8-1:0] data_wben;
    logic                      read_data_en;
    logic                      read_tag_en;
    logic [1:0]                word_sel;
    logic                      mem_write;
  } dpath_ctrl_t;

  typedef struct packed {
    mem_op_e    op;
    addr_t      addr;
    logic [1:0] tag_match;
  } dpath_status_t;

endpackage

// File: rtl/cache_sram.sv
/*
 * Register array with a combinational read port and a
 * byte-masked synchronous write port
 */

`timescale 1ns/1ps

module cache_sram #(
  parameter int unsigned WIDTH = 128,
  parameter int unsigned DEPTH = 16
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  output logic [WIDTH-1:0]         rd_data,
  input  logic                     wen,
  input  logic [(WIDTH+7)/8-1:0]   wben,
  input  logic [WIDTH-1:0]         wr_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  assign rd_data = mem[rd_addr];

  // Each bit follows the enable of the byte it sits in
  always_ff @(posedge clk) begin
    if (wen) begin
      for (int i = 0; i < WIDTH; i++) begin
        if (wben[i/8]) begin
          mem[wr_addr][i] <= wr_data[i];
        end
      end
    end
  end

endmodule

// File: rtl/blocking_cache_dpath.sv
/*
 * Blocking cache datapath: request and refill registers, tag and data
 * arrays, tag compare, AMO unit and message packing
 */

`timescale 1ns/1ps

`include "cache_defines.svh"

module blocking_cache_dpath
  import cache_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  cache_req_t    req,
  input  line_t         memresp_data,
  input  dpath_ctrl_t   ctrl,
  output dpath_status_t status,
  output word_t         resp_data,
  output opq_t          resp_opaque,
  output mem_req_t      memreq
);

  localparam int unsigned WORDS = `CACHE_LINE_W / `CACHE_WORD_W;

  cache_req_t req_q;
  line_t      memresp_q;
  line_t      data_rd;
  line_t      read_data_q;
  line_t      write_line;
  line_t      refill_line;
  tag_t       tag;
  tag_t       tag_0_rd;
  tag_t       tag_1_rd;
  tag_t       victim_tag;
  tag_t       read_tag_q;
  idx_t       idx;
  word_t      old_word;
  word_t      write_word;

  // ==========================================================================
  // Input registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= '0;
    end else if (ctrl.req_en) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.memresp_en) begin
      memresp_q <= memresp_data;
    end
  end

  // Address slices of the held request
  assign tag = req_q.addr[`CACHE_ADDR_W-1:`CACHE_OFF_W];
  assign idx = req_q.addr[`CACHE_OFF_W +: `CACHE_IDX_W];

  // ==========================================================================
  // Arrays
  // ==========================================================================

  cache_sram #(
    .WIDTH ($bits(tag_t)),
    .DEPTH (`CACHE_NUM_SETS)
  ) tag_array_0 (
    .clk     (clk),
    .rd_addr (idx),
    .wr_addr (idx),
    .rd_data (tag_0_rd),
    .wen     (ctrl.tag_wen[0]),
    .wben    ('1),
    .wr_data (tag)
  );

  cache_sram #(
    .WIDTH ($bits(tag_t)),
    .DEPTH (`CACHE_NUM_SETS)
  ) tag_array_1 (
    .clk     (clk),
    .rd_addr (idx),
    .wr_addr (idx),
    .rd_data (tag_1_rd),
    .wen     (ctrl.tag_wen[1]),
    .wben    ('1),
    .wr_data (tag)
  );

  // Lines of one set sit next to each other, way in the low bit
  cache_sram #(
    .WIDTH (`CACHE_LINE_W),
    .DEPTH (2 * `CACHE_NUM_SETS)
  ) data_array (
    .clk     (clk),
    .rd_addr ({idx, ctrl.way_sel}),
    .wr_addr ({idx, ctrl.way_sel}),
    .rd_data (data_rd),
    .wen     (ctrl.data_wen),
    .wben    (ctrl.data_wben),
    .wr_data (refill_line)
  );

  assign status.tag_match[0] = (tag == tag_0_rd);
  assign status.tag_match[1] = (tag == tag_1_rd);
  assign status.op           = req_q.op;
  assign status.addr         = req_q.addr;

  // Tag of the selected way, kept for a writeback
  assign victim_tag = ctrl.way_sel ? tag_1_rd : tag_0_rd;

  always_ff @(posedge clk) begin
    if (ctrl.read_data_en) begin
      read_data_q <= data_rd;
    end
    if (ctrl.read_tag_en) begin
      read_tag_q <= victim_tag;
    end
  end

  // ==========================================================================
  // Word select and AMO unit
  // ==========================================================================

  assign old_word = read_data_q[ctrl.word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

  always_comb begin
    case (req_q.op)
      OP_AMO_ADD: write_word = req_q.data + old_word;
      OP_AMO_AND: write_word = req_q.data & old_word;
      OP_AMO_OR:  write_word = req_q.data | old_word;
      default:    write_word = req_q.data;
    endcase
  end

  // Byte enables pick the addressed copy
  assign write_line  = {WORDS{write_word}};
  assign refill_line = ctrl.is_refill ? memresp_q : write_line;

  // ==========================================================================
  // Outgoing messages
  // ==========================================================================

  assign resp_data   = old_word;
  assign resp_opaque = req_q.opaque;

  assign memreq.write = ctrl.mem_write;
  assign memreq.addr  = {(ctrl.mem_write ? read_tag_q : tag), {`CACHE_OFF_W{1'b0}}};
  assign memreq.data  = read_data_q;

endmodule

// File: rtl/blocking_cache_ctrl.sv
/*
 * Blocking cache control unit: request FSM, valid, dirty and LRU
 * state, victim choice and the datapath enables
 */

`timescale 1ns/1ps

`include "cache_defines.svh"

module blocking_cache_ctrl
  import cache_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req_val,
  input  logic          memresp_val,
  input  dpath_status_t status,
  output dpath_ctrl_t   ctrl,
  output logic          busy,
  output logic          resp_val,
  output logic          memreq_val
);

  localparam int unsigned WBEN_W = `CACHE_LINE_W / 8;

  typedef enum logic [2:0] {
    IDLE,
    TAG_CHECK,
    RESPOND,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL
  } state_e;

  state_e                          state_q;
  state_e                          state_d;
  logic                            way_q;
  logic                            way_d;
  logic [`CACHE_NUM_SETS-1:0][1:0] valid_q;
  logic [`CACHE_NUM_SETS-1:0][1:0] dirty_q;
  logic [`CACHE_NUM_SETS-1:0]      lru_q;
  idx_t                            idx;
  logic [1:0]                      word;
  logic [1:0]                      match;
  logic                            hit;
  logic                            victim;
  logic                            is_write;

  assign idx      = status.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
  assign word     = status.addr[`CACHE_OFF_W-1:2];
  assign is_write = (status.op != OP_READ);

  // Stale tags of invalid lines never hit
  assign match = status.tag_match & valid_q[idx];
  assign hit   = |match;

  // Invalid way first, way 0 preferred, else the LRU way
  always_comb begin
    if (!valid_q[idx][0]) begin
      victim = 1'b0;
    end else if (!valid_q[idx][1]) begin
      victim = 1'b1;
    end else begin
      victim = lru_q[idx];
    end
  end

  // ==========================================================================
  // Next state and datapath enables
  // ==========================================================================

  always_comb begin
    state_d       = state_q;
    way_d         = way_q;
    ctrl          = '0;
    ctrl.way_sel  = way_q;
    ctrl.word_sel = word;
    case (state_q)
      IDLE: begin
        if (req_val) begin
          ctrl.req_en = 1'b1;
          state_d     = TAG_CHECK;
        end
      end
      TAG_CHECK: begin
        ctrl.read_data_en = 1'b1;
        if (hit) begin
          way_d   = match[1];
          state_d = RESPOND;
        end else begin
          // Victim line and tag are loaded for a possible writeback
          way_d            = victim;
          ctrl.read_tag_en = 1'b1;
          state_d          = dirty_q[idx][victim] ? EVICT_REQ : REFILL_REQ;
        end
        ctrl.way_sel = way_d;
      end
      RESPOND: begin
        if (is_write) begin
          ctrl.data_wen  = 1'b1;
          ctrl.data_wben = {{(WBEN_W-4){1'b0}}, 4'hf} << {word, 2'b00};
        end
        state_d = IDLE;
      end
      EVICT_REQ: begin
        ctrl.mem_write = 1'b1;
        state_d        = EVICT_WAIT;
      end
      EVICT_WAIT: begin
        ctrl.mem_write = 1'b1;
        if (memresp_val) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        state_d = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        ctrl.memresp_en = memresp_val;
        if (memresp_val) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        ctrl.is_refill      = 1'b1;
        ctrl.data_wen       = 1'b1;
        ctrl.data_wben      = '1;
        ctrl.tag_wen[way_q] = 1'b1;
        // Back to tag check, which now hits
        state_d             = TAG_CHECK;
      end
      default: state_d = IDLE;
    endcase
  end

  assign busy       = (state_q != IDLE);
  assign resp_val   = (state_q == RESPOND);
  assign memreq_val = (state_q == EVICT_REQ) || (state_q == REFILL_REQ);

  // ==========================================================================
  // State registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      way_q   <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      state_q <= state_d;
      way_q   <= way_d;
      if (state_q == REFILL) begin
        valid_q[idx][way_q] <= 1'b1;
        dirty_q[idx][way_q] <= 1'b0;
      end
      if (state_q == RESPOND) begin
        // The other way becomes least recently used
        lru_q[idx] <= ~way_q;
        if (is_write) begin
          dirty_q[idx][way_q] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/blocking_cache.sv
/*
 * Two-way set-associative write-back blocking cache, top level
 */

`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // Processor side
  input  logic        req_val,
  input  cache_req_t  req,
  output logic        busy,
  output logic        resp_val,
  output cache_resp_t resp,
  // Memory side
  output logic        memreq_val,
  output mem_req_t    memreq,
  input  logic        memresp_val,
  input  line_t       memresp_data
);

  dpath_ctrl_t   ctrl;
  dpath_status_t status;
  word_t         resp_data;
  opq_t          resp_opaque;

  blocking_cache_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_val     (req_val),
    .memresp_val (memresp_val),
    .status      (status),
    .ctrl        (ctrl),
    .busy        (busy),
    .resp_val    (resp_val),
    .memreq_val  (memreq_val)
  );

  blocking_cache_dpath dpath_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .memresp_data (memresp_data),
    .ctrl         (ctrl),
    .status       (status),
    .resp_data    (resp_data),
    .resp_opaque  (resp_opaque),
    .memreq       (memreq)
  );

  assign resp.op     = status.op;
  assign resp.opaque = resp_opaque;
  assign resp.data   = resp_data;

endmodule

// File: tests/blocking_cache_checker.sv
/*
 * Strobe and pulse protocol assertions for the blocking cache
 */

`timescale 1ns/1ps

module blocking_cache_checker (
  input logic clk,
  input logic rst_n,
  input logic req_val,
  input logic busy,
  input logic resp_val,
  input logic memreq_val
);

  // Single-cycle pulses
  assert property (@(posedge clk) disable iff (!rst_n) resp_val |=> !resp_val)
    else $error("resp_val held high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) memreq_val |=> !memreq_val)
    else $error("memreq_val held high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) !(resp_val && memreq_val))
    else $error("resp_val and memreq_val high together");

  // Requester keeps off while the cache is busy
  assert property (@(posedge clk) disable iff (!rst_n) req_val |-> !busy)
    else $error("req_val raised while busy");

  // Quiet outputs right after reset
  assert property (@(posedge clk) $rose(rst_n) |-> !busy && !resp_val && !memreq_val)
    else $error("outputs not low in the cycle after reset");

endmodule

bind blocking_cache blocking_cache_checker checker_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_val    (req_val),
  .busy       (busy),
  .resp_val   (resp_val),
  .memreq_val (memreq_val)
);

// File: tests/blocking_cache_tb.sv
/*
 * Testbench for the blocking cache with a memory model, a word-level
 * reference model and directed tests through the processor port
 */

`timescale 1ns/1ps

module blocking_cache_tb
  import cache_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_val;
  cache_req_t  req;
  logic        busy;
  logic        resp_val;
  cache_resp_t resp;
  logic        memreq_val;
  mem_req_t    memreq;
  logic        memresp_val;
  line_t       memresp_data;

  // Memory model and reference model state
  line_t    mem_lines [addr_t];
  mem_req_t mem_log [$];
  mem_req_t mem_cur;
  int       mem_count = 0;
  word_t    ref_mem [addr_t];
  opq_t     opq_next = '0;
  int       seed = 34323;

  blocking_cache blocking_cache_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_val      (req_val),
    .req          (req),
    .busy         (busy),
    .resp_val     (resp_val),
    .resp         (resp),
    .memreq_val   (memreq_val),
    .memreq       (memreq),
    .memresp_val  (memresp_val),
    .memresp_data (memresp_data)
  );

  always #10 clk = ~clk;

  // ==========================================================================
  // Reference values
  // ==========================================================================

  // Word k of the line at A holds A + k
  function automatic word_t init_word(addr_t a);
    return (a & ~32'hf) + {30'd0, a[3:2]};
  endfunction

  function automatic line_t init_line(addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*32 +: 32] = init_word(a + 32'(4 * k));
    end
    return l;
  endfunction

  function automatic word_t ref_read(addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return init_word(a);
  endfunction

  function automatic line_t ref_line(addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*32 +: 32] = ref_read((a & ~32'hf) + 32'(4 * k));
    end
    return l;
  endfunction

  function automatic word_t apply_op(mem_op_e op, word_t old, word_t data);
    case (op)
      OP_AMO_ADD: return old + data;
      OP_AMO_AND: return old & data;
      OP_AMO_OR:  return old | data;
      default:    return data;
    endcase
  endfunction

  // ==========================================================================
  // Memory model
  // ==========================================================================

  // Latency cycles through one to three cycles
  always @(negedge clk) begin
    if (rst_n && memreq_val) begin
      mem_cur = memreq;
      mem_log.push_back(mem_cur);
      if (mem_cur.write) begin
        mem_lines[mem_cur.addr] = mem_cur.data;
      end
      repeat (1 + mem_count % 3) @(posedge clk);
      mem_count++;
      #1;
      memresp_val  = 1'b1;
      memresp_data = '0;
      if (!mem_cur.write) begin
        memresp_data = mem_lines.exists(mem_cur.addr) ? mem_lines[mem_cur.addr]
                                                      : init_line(mem_cur.addr);
      end
      @(posedge clk);
      #1;
      memresp_val = 1'b0;
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_on_error();
    end
  endtask

  task automatic check_opaque(input string name, input opq_t exp, input opq_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic expect_mem_reqs(input string name, input int n);
    if (mem_log.size() != n) begin
      $display("%s: saw %0d memory requests instead of %0d", name, mem_log.size(), n);
      stop_on_error();
    end
  endtask

  task automatic wait_idle(input string name);
    int timer;
    timer = 0;
    while (busy) begin
      @(negedge clk);
      timer++;
      if (timer > TIMEOUT) begin
        $display("%s: cache never went idle", name);
        stop_on_error();
      end
    end
  endtask

  // Issues one request and checks it against the reference model
  task automatic access(input string name, input mem_op_e op, input addr_t addr,
                        input word_t data, output int cycles);
    word_t old_word;
    int    refills;
    line_t wb_line;
    old_word = ref_read(addr);
    opq_next++;
    wait_idle(name);
    mem_log.delete();
    @(posedge clk);
    #1;
    req_val    = 1'b1;
    req.op     = op;
    req.opaque = opq_next;
    req.addr   = addr;
    req.data   = data;
    @(posedge clk);
    #1;
    req_val = 1'b0;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (!busy) begin
        $display("%s: busy fell before resp_val", name);
        stop_on_error();
      end
      if (cycles > TIMEOUT) begin
        $display("%s: resp_val never came", name);
        stop_on_error();
      end
    end while (!resp_val);
    check_op(name, op, resp.op);
    check_opaque(name, opq_next, resp.opaque);
    check_word(name, old_word, resp.data);
    // Writebacks come first and carry the reference line
    refills = 0;
    foreach (mem_log[i]) begin
      if (mem_log[i].write) begin
        if (refills != 0) begin
          $display("%s: writeback issued after the refill", name);
          stop_on_error();
        end
        wb_line = ref_line(mem_log[i].addr);
        for (int k = 0; k < 4; k++) begin
          check_word(name, wb_line[k*32 +: 32], mem_log[i].data[k*32 +: 32]);
        end
      end else begin
        refills++;
        check_addr(name, addr & ~32'hf, mem_log[i].addr);
      end
    end
    if (mem_log.size() > 0 && refills != 1) begin
      $display("%s: miss did not end with exactly one refill", name);
      stop_on_error();
    end
    if (op != OP_READ) begin
      ref_mem[addr] = apply_op(op, old_word, data);
    end
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic test_read_miss_hit();
    int cycles;
    access("read miss", OP_READ, 32'h1008, '0, cycles);
    expect_mem_reqs("read miss", 1);
    access("read hit", OP_READ, 32'h1008, '0, cycles);
    expect_mem_reqs("read hit", 0);
    if (cycles != 2) begin
      $display("read hit: response took %0d cycles instead of 2", cycles);
      stop_on_error();
    end
  endtask

  task automatic test_write_read();
    int cycles;
    access("write hit", OP_WRITE, 32'h1004, 32'hcafe_f00d, cycles);
    expect_mem_reqs("write hit", 0);
    access("read back", OP_READ, 32'h1004, '0, cycles);
    access("word 0 kept", OP_READ, 32'h1000, '0, cycles);
    access("word 3 kept", OP_READ, 32'h100c, '0, cycles);
    expect_mem_reqs("word 3 kept", 0);
  endtask

  task automatic test_atomics();
    int cycles;
    access("amo add", OP_AMO_ADD, 32'h1008, 32'h0000_0010, cycles);
    access("amo add result", OP_READ, 32'h1008, '0, cycles);
    access("amo and", OP_AMO_AND, 32'h1008, 32'h0000_0ff0, cycles);
    access("amo and result", OP_READ, 32'h1008, '0, cycles);
    access("amo or", OP_AMO_OR, 32'h1008, 32'h5a00_0003, cycles);
    access("amo or result", OP_READ, 32'h1008, '0, cycles);
    expect_mem_reqs("amo or result", 0);
  endtask

  // Lines 0x2050, 0x2150 and 0x2250 share set 5
  task automatic test_eviction();
    int cycles;
    access("fill way 0", OP_WRITE, 32'h2050, 32'h1111_aaaa, cycles);
    access("fill way 1", OP_WRITE, 32'h2154, 32'h2222_bbbb, cycles);
    access("evict", OP_READ, 32'h2258, '0, cycles);
    expect_mem_reqs("evict", 2);
    if (!mem_log[0].write) begin
      $display("evict: first memory request is not a writeback");
      stop_on_error();
    end
    check_addr("evict", 32'h2050, mem_log[0].addr);
    access("refill evicted", OP_READ, 32'h2050, '0, cycles);
    expect_mem_reqs("refill evicted", 2);
    check_addr("refill evicted", 32'h2150, mem_log[0].addr);
  endtask

  // Eight lines over sets 1 and 2
  task automatic test_random_mix();
    int         cycles;
    logic [2:0] pick;
    logic [2:0] sel;
    logic [1:0] word;
    addr_t      addr;
    word_t      data;
    for (int i = 0; i < 200; i++) begin
      pick = 3'($unsigned($random(seed)) % 5);
      sel  = 3'($random(seed));
      word = 2'($random(seed));
      data = $random(seed);
      addr = 32'h4000 + 32'(sel[2:1]) * 32'h80 + (sel[0] ? 32'h20 : 32'h10)
             + 32'(word) * 4;
      access("random mix", mem_op_e'(pick), addr, data, cycles);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    req_val      = 1'b0;
    req          = '0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_read_miss_hit();
    test_write_read();
    test_atomics();
    test_eviction();
    test_random_mix();
    wait_idle("end of run");
    $display("No errors");
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_sram.sv
rtl/blocking_cache_dpath.sv
rtl/blocking_cache_ctrl.sv
rtl/blocking_cache.sv
tests/blocking_cache_checker.sv
tests/blocking_cache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module blocking_cache_tb -Mdir obj_dir -f files.f &&
  ./obj_dir/Vblocking_cache_tb | tee /dev/stderr | grep -q "No errors" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
